// File: build.f
hdl/i2c_pkg.sv
hdl/i2c_ctrl_if.sv
hdl/i2c_regs.sv
hdl/i2c_scl_div.sv
hdl/i2c_engine.sv
hdl/i2c_master_top.sv
test/i2c_slave_model.sv
test/i2c_master_tb.sv

// File: run.sh
#!/bin/sh
# Compile the I2C master testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
	--top-module i2c_master_tb \
	-f build.f \
	--Mdir obj_dir -o i2c_master_tb

./obj_dir/i2c_master_tb > sim.log 2>&1 || true
cat sim.log

grep -q "RESULT: PASS" sim.log

// File: test/i2c_master_tb.sv
`timescale 1ns/100ps

module i2c_master_tb;
	import i2c_pkg::*;

	localparam int          CLK_DIV    = 4;
	localparam int          PERIOD     = 8;
	localparam slave_addr_t SLAVE_ADDR = 7'h2A;
	localparam int          XFER_BITS  = 1 + 9 * 5 + 1;  // Start, address and four bytes, stop
	localparam int          XFER_CYC   = XFER_BITS * 4 * CLK_DIV;
	localparam int          N_XFER     = 4;
	localparam int          BUS_CYC    = 400;            // Register accesses around the transfers
	localparam int          WDOG_NS    = 2 * (N_XFER * XFER_CYC + BUS_CYC) * PERIOD;
	localparam word_t       M_WR_GO    = 32'd1 << CFG_WR_GO;
	localparam word_t       M_WR_DONE  = 32'd1 << CFG_WR_DONE;
	localparam word_t       M_RD_GO    = 32'd1 << CFG_RD_GO;
	localparam word_t       M_RD_DONE  = 32'd1 << CFG_RD_DONE;
	localparam word_t       M_NACK     = 32'd1 << CFG_NACK;
	localparam word_t       M_CLEAR    = M_WR_DONE | M_RD_DONE | M_NACK;

	logic      clk;
	logic      rst;
	logic      write;
	byte_en_t  data_be;
	reg_addr_t addr;
	word_t     wdata;
	word_t     rdata;
	logic      sda_oe;
	logic      scl_oe;
	logic      slv_sda_oe;
	logic      scl;
	logic      sda;
	int        seed;
	int        errors;
	int        n_tests;
	int        n_failed;

	assign scl = ~scl_oe;                  // Pull-ups with open-drain pull-downs
	assign sda = ~sda_oe & ~slv_sda_oe;

	i2c_master_top #(.CLK_DIV(CLK_DIV)) DUT (
		.clk_i(clk), .rst_i(rst), .write_i(write), .data_be_i(data_be), .addr_i(addr),
		.wdata_i(wdata), .rdata_o(rdata), .sda_i(sda), .sda_oe_o(sda_oe), .scl_oe_o(scl_oe)
	);

	i2c_slave_model #(.ADDR(SLAVE_ADDR)) u_slave (.scl_i(scl), .sda_i(sda), .sda_oe_o(slv_sda_oe));

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WDOG_NS);
		$display("Watchdog expired after %0d ns, a transfer never finished", WDOG_NS);
		$display("RESULT: FAIL");
		$finish;
	end

	task automatic check_value(input string name, input word_t got, input word_t exp);
		if (got !== exp) begin
			$display("Fail %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		n_tests++;
		if (errors == err_before) begin
			$display("Test %s: ok", name);
		end else begin
			n_failed++;
			$display("Test %s: failed with %0d errors", name, errors - err_before);
		end
	endtask

	task automatic bus_write(input reg_addr_t a, input byte_en_t be, input word_t d);
		@(posedge clk);
		#1;
		write   = 1'b1;
		addr    = a;
		data_be = be;
		wdata   = d;
		@(posedge clk);
		#1;
		write   = 1'b0;
		data_be = '0;
		wdata   = '0;
	endtask

	task automatic bus_read(input reg_addr_t a, input byte_en_t be, output word_t d);
		@(posedge clk);
		#1;
		addr    = a;
		data_be = be;
		#(PERIOD / 2);
		d = rdata;                             // Sampled mid-cycle
	endtask

	task automatic wait_done(input int bit_pos);
		word_t cfg;
		int    polls;
		cfg   = '0;
		polls = 0;
		while (cfg[bit_pos] !== 1'b1 && polls < 2 * XFER_CYC) begin
			bus_read(REG_CFG, 4'b0001, cfg);
			polls++;
		end
		if (cfg[bit_pos] !== 1'b1) begin
			$display("Done bit %0d never came up within %0d polls", bit_pos, polls);
			errors++;
		end
	endtask

	task automatic setup_xfer(input slave_addr_t adr, input byte_cnt_t nby, input word_t tdr);
		bus_write(REG_ADR, 4'b0001, word_t'(adr));
		bus_write(REG_NBY, 4'b0001, word_t'(nby));
		bus_write(REG_TDR, 4'b1111, tdr);
	endtask

	task automatic access_registers();
		int    err0;
		word_t r;
		word_t d;
		word_t t;
		word_t e;
		err0 = errors;
		bus_read(REG_CFG, 4'b1111, r);
		check_value("cfg after reset", r, 32'h0);
		check_value("scl_oe after reset", word_t'(scl_oe), 32'h0);
		check_value("sda_oe after reset", word_t'(sda_oe), 32'h0);
		bus_write(REG_NBY, 4'b1111, 32'hFFFF_FF01);  // Upper lanes hit unmapped bytes
		bus_read(REG_NBY, 4'b1111, r);
		check_value("nby", r, 32'h0000_0001);
		bus_write(REG_NBY, 4'b0001, 32'h0);
		bus_write(REG_NBY, 4'b0010, 32'h0000_0300);
		bus_read(REG_NBY, 4'b1111, r);
		check_value("nby four bytes", r, 32'h0000_0004);
		bus_write(REG_ADR, 4'b0001, 32'h15);
		bus_read(REG_ADR, 4'b1111, r);
		check_value("adr", r, 32'h15);
		bus_read(REG_ADR, 4'b1110, r);
		check_value("adr masked", r, 32'h0);
		d = $random(seed);
		t = $random(seed);
		bus_write(REG_TDR, 4'b1111, d);
		bus_read(REG_TDR, 4'b1111, r);
		check_value("tdr", r, d);
		bus_write(REG_TDR, 4'b0101, t);
		e = {d[31:24], t[23:16], d[15:8], t[7:0]};
		bus_read(REG_TDR, 4'b0110, r);
		check_value("tdr lanes", r, {8'h00, e[23:8], 8'h00});
		bus_write(REG_TDR + 5'd3, 4'b0001, 32'hA5);
		bus_read(REG_TDR + 5'd2, 4'b0011, r);
		check_value("tdr offset", r, {16'h0, 8'hA5, e[23:16]});
		bus_read(5'h14, 4'b1111, r);
		check_value("unmapped", r, 32'h0);
		report_test("register access", err0);
	endtask

	task automatic write_transfer();
		int    err0;
		int    base;
		word_t r;
		word_t tdr;
		err0 = errors;
		tdr  = $random(seed);
		base = u_slave.log_cnt;
		setup_xfer(SLAVE_ADDR, 2'd2, tdr);
		bus_write(REG_CFG, 4'b0001, M_CLEAR | M_WR_GO);
		wait_done(CFG_WR_DONE);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg", r, M_WR_DONE);
		check_value("slave log count", u_slave.log_cnt - base, 2);
		check_value("slave byte 0", word_t'(u_slave.log_byte[base]), word_t'(tdr[7:0]));
		check_value("slave byte 1", word_t'(u_slave.log_byte[base + 1]), word_t'(tdr[15:8]));
		report_test("write transfer", err0);
	endtask

	task automatic read_transfer();
		int    err0;
		int    mbase;
		word_t r;
		err0  = errors;
		mbase = u_slave.mack_cnt;
		setup_xfer(SLAVE_ADDR, 2'd0, 32'h0);
		bus_write(REG_CFG, 4'b0001, M_CLEAR | M_RD_GO);
		wait_done(CFG_RD_DONE);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg", r, M_RD_DONE);
		bus_read(REG_RDR, 4'b1111, r);
		check_value("rdr", r, {u_slave.mem[3], u_slave.mem[2], u_slave.mem[1], u_slave.mem[0]});
		check_value("master ack count", u_slave.mack_cnt - mbase, 4);
		for (int k = 0; k < 4; k++) begin
			check_value($sformatf("master ack %0d", k), word_t'(u_slave.mack[mbase + k]),
				word_t'(k == 3));              // Last byte is NACKed
		end
		report_test("read transfer", err0);
	endtask

	task automatic wrong_address();
		int    err0;
		int    base;
		word_t r;
		err0 = errors;
		base = u_slave.log_cnt;
		setup_xfer(7'h15, 2'd1, $random(seed));
		bus_write(REG_CFG, 4'b0001, M_CLEAR | M_WR_GO);
		wait_done(CFG_WR_DONE);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg", r, M_WR_DONE | M_NACK);
		check_value("slave log count", u_slave.log_cnt - base, 0);
		report_test("wrong address", err0);
	endtask

	task automatic clear_and_reuse();
		int    err0;
		int    base;
		word_t r;
		word_t tdr;
		err0 = errors;
		bus_write(REG_CFG, 4'b0001, M_WR_DONE);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg after done clear", r, M_NACK);
		bus_write(REG_CFG, 4'b0001, M_NACK);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg after nack clear", r, 32'h0);
		tdr  = $random(seed);
		base = u_slave.log_cnt;
		setup_xfer(SLAVE_ADDR, 2'd3, tdr);
		bus_write(REG_CFG, 4'b0001, M_WR_GO);
		bus_write(REG_CFG, 4'b0001, M_WR_GO | M_RD_GO);  // Busy, must be dropped
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg busy", r, M_WR_GO);
		wait_done(CFG_WR_DONE);
		repeat (20) @(posedge clk);
		bus_read(REG_CFG, 4'b0001, r);
		check_value("cfg after reuse", r, M_WR_DONE);
		check_value("scl_oe idle", word_t'(scl_oe), 32'h0);
		check_value("sda_oe idle", word_t'(sda_oe), 32'h0);
		check_value("slave log count", u_slave.log_cnt - base, 3);
		for (int k = 0; k < 3; k++) begin
			check_value($sformatf("slave byte %0d", k), word_t'(u_slave.log_byte[base + k]),
				word_t'(tdr[8*k +: 8]));
		end
		report_test("clear and reuse", err0);
	endtask

	initial begin
		seed     = 32'h33c1_bbc5;
		errors   = 0;
		n_tests  = 0;
		n_failed = 0;
		rst      = 1'b1;
		write    = 1'b0;
		data_be  = '0;
		addr     = '0;
		wdata    = '0;
		repeat (3) @(posedge clk);
		#1;
		rst = 1'b0;
		access_registers();
		write_transfer();
		read_transfer();
		wrong_address();
		clear_and_reuse();
		$display("%0d tests run, %0d failed, %0d check errors", n_tests, n_failed, errors);
		if (errors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

// File: test/i2c_slave_model.sv
`timescale 1ns/100ps

module i2c_slave_model #(
	parameter logic [6:0] ADDR = 7'h2A
) (
	input  logic scl_i,
	input  logic sda_i,
	output logic sda_oe_o = 1'b0
);

	typedef enum logic [2:0] {SL_IDLE, SL_ADDR, SL_SACK, SL_RX, SL_TX, SL_MACK} sl_state_e;

	logic [7:0] mem [4];
	logic [7:0] log_byte [32];      // Bytes written by the master
	int         log_cnt = 0;
	logic       mack [32];          // Master acknowledge bits, 0 means ACK
	int         mack_cnt = 0;

	sl_state_e  state = SL_IDLE;
	logic [7:0] sh = 8'h00;
	int         bitn = 0;
	logic       rnw = 1'b0;
	logic       macked = 1'b0;
	logic [1:0] rd_ptr = 2'd0;
	logic       scl_q = 1'b1;
	logic       sda_q = 1'b1;

	initial begin
		for (int a = 0; a < 4; a++) begin
			mem[a] = 8'h3C ^ 8'(a * 8'h59);
		end
	end

	task automatic send_byte();
		sh       = mem[rd_ptr];
		bitn     = 0;
		sda_oe_o = ~sh[7];
		state    = SL_TX;
	endtask

	always @(scl_i or sda_i) begin
		if (scl_i !== scl_q) begin
			if (scl_i === 1'b1) begin
				case (state)
					SL_ADDR, SL_RX: begin
						sh   = {sh[6:0], sda_i};
						bitn = bitn + 1;
					end
					SL_TX: bitn = bitn + 1;
					SL_MACK: begin
						macked             = ~sda_i;
						mack[mack_cnt]     = sda_i;
						mack_cnt           = mack_cnt + 1;
					end
					default: ;
				endcase
			end else if (scl_i === 1'b0) begin
				case (state)
					SL_ADDR: if (bitn == 8) begin
						if (sh[7:1] == ADDR) begin
							rnw      = sh[0];
							sda_oe_o = 1'b1;   // Address ACK
							state    = SL_SACK;
						end else begin
							state = SL_IDLE;
						end
					end
					SL_RX: if (bitn == 8) begin
						log_byte[log_cnt] = sh;
						log_cnt           = log_cnt + 1;
						sda_oe_o          = 1'b1;
						state             = SL_SACK;
					end
					SL_SACK: begin
						if (rnw) begin
							send_byte();
						end else begin
							sda_oe_o = 1'b0;
							bitn     = 0;
							state    = SL_RX;
						end
					end
					SL_TX: if (bitn == 8) begin
						sda_oe_o = 1'b0;       // Let the master answer
						state    = SL_MACK;
					end else begin
						sh       = {sh[6:0], 1'b0};
						sda_oe_o = ~sh[7];
					end
					SL_MACK: begin
						if (macked) begin
							rd_ptr = rd_ptr + 2'd1;
							send_byte();
						end else begin
							state = SL_IDLE;
						end
					end
					default: ;
				endcase
			end
		end else if (sda_i !== sda_q && scl_i === 1'b1) begin
			sda_oe_o = 1'b0;
			if (sda_i === 1'b0) begin
				state  = SL_ADDR;             // Start condition
				bitn   = 0;
				rd_ptr = 2'd0;
			end else begin
				state = SL_IDLE;              // Stop condition
			end
		end
		scl_q = scl_i;
		sda_q = sda_i;
	end

endmodule

// File: hdl/i2c_master_top.sv
`timescale 1ns/100ps

module i2c_master_top #(
	parameter int CLK_DIV = 4
) (
	input  logic               clk_i,
	input  logic               rst_i,
	input  logic               write_i,
	input  i2c_pkg::byte_en_t  data_be_i,
	input  i2c_pkg::reg_addr_t addr_i,
	input  i2c_pkg::word_t     wdata_i,
	output i2c_pkg::word_t     rdata_o,
	input  logic               sda_i,
	output logic               sda_oe_o,
	output logic               scl_oe_o
);

	logic run;
	logic tick;

	i2c_ctrl_if ctrl ();

	i2c_regs u_regs (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.write_i   (write_i),
		.data_be_i (data_be_i),
		.addr_i    (addr_i),
		.wdata_i   (wdata_i),
		.rdata_o   (rdata_o),
		.ctrl      (ctrl.regs)
	);

	i2c_scl_div #(
		.CLK_DIV (CLK_DIV)
	) u_div (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.run_i  (run),
		.tick_o (tick)
	);

	i2c_engine u_engine (
		.clk_i    (clk_i),
		.rst_i    (rst_i),
		.tick_i   (tick),
		.sda_i    (sda_i),
		.run_o    (run),
		.sda_oe_o (sda_oe_o),
		.scl_oe_o (scl_oe_o),
		.ctrl     (ctrl.engine)
	);

endmodule

// File: hdl/i2c_engine.sv
`timescale 1ns/100ps

module i2c_engine (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic        tick_i,
	input  logic        sda_i,
	output logic        run_o,
	output logic        sda_oe_o,
	output logic        scl_oe_o,
	i2c_ctrl_if.engine  ctrl
);
	import i2c_pkg::*;

	eng_state_e  state;
	logic [1:0]  q;         // Quarter within the current bit
	logic [2:0]  bcnt;      // Bit within the byte, MSB first
	byte_cnt_t   byte_idx;

	logic [7:0]  sh_addr;   // Address byte with rnw in bit 0
	word_t       sh_tx;
	byte_cnt_t   sh_nby;

	logic        start_go;
	logic        bit_end;
	logic        sample;
	logic        last_byte;
	byte_cnt_t   last_idx;

	assign start_go  = (state == IDLE) && !ctrl.ack && ctrl.req;
	assign bit_end   = tick_i && (q == 2'd3);
	assign sample    = tick_i && (q == 2'd2);  // Third tick, SCL still high
	assign last_idx  = sh_nby - 2'd1;          // Wraps to 3 for a count of four
	assign last_byte = (byte_idx == last_idx);
	assign run_o     = (state != IDLE);

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			state    <= IDLE;
			q        <= 2'd0;
			bcnt     <= 3'd0;
			byte_idx <= 2'd0;
			ctrl.ack <= 1'b0;
		end else begin
			if (state != IDLE && tick_i) q <= q + 2'd1;
			case (state)
				IDLE: begin
					q <= 2'd0;
					if (ctrl.ack) begin
						if (!ctrl.req) ctrl.ack <= 1'b0; // Close the handshake
					end else if (ctrl.req) begin
						state    <= START;
						byte_idx <= 2'd0;
					end
				end
				START: if (bit_end) begin
					state <= ADDR;
					bcnt  <= 3'd7;
				end
				ADDR: if (bit_end) begin
					bcnt <= bcnt - 3'd1;
					if (bcnt == 3'd0) state <= ACK0;
				end
				ACK0: if (bit_end) begin
					bcnt <= 3'd7;
					if (ctrl.nack)      state <= STOP; // No slave answered
					else if (sh_addr[0]) state <= RDATA;
					else                 state <= WDATA;
				end
				WDATA, RDATA: if (bit_end) begin
					bcnt <= bcnt - 3'd1;
					if (bcnt == 3'd0) state <= ACK1;
				end
				ACK1: if (bit_end) begin
					if (last_byte) begin
						state <= STOP;
					end else begin
						byte_idx <= byte_idx + 2'd1;
						bcnt     <= 3'd7;
						state    <= sh_addr[0] ? RDATA : WDATA;
					end
				end
				STOP: if (bit_end) begin
					state    <= IDLE;
					ctrl.ack <= 1'b1;
				end
				default: state <= IDLE;
			endcase
		end
	end

	// Operands captured at start, results collected during the transfer
	always_ff @(posedge clk_i) begin
		if (start_go) begin
			sh_addr   <= {ctrl.slave_addr, ctrl.rnw};
			sh_tx     <= ctrl.tdr;
			sh_nby    <= ctrl.nby;
			ctrl.rdr  <= '0;
			ctrl.nack <= 1'b0;
		end else if (sample) begin
			if (state == ACK0)  ctrl.nack <= sda_i;
			if (state == RDATA) ctrl.rdr[{byte_idx, bcnt}] <= sda_i;
		end
	end

	// Open-drain drive, SCL released in the middle two quarters of a bit
	always_comb begin
		sda_oe_o = 1'b0;
		scl_oe_o = (q == 2'd0) || (q == 2'd3);
		case (state)
			IDLE: scl_oe_o = 1'b0;
			START: begin
				sda_oe_o = (q != 2'd0);   // SDA falls while SCL is high
				scl_oe_o = (q == 2'd3);
			end
			ADDR:  sda_oe_o = ~sh_addr[bcnt];
			WDATA: sda_oe_o = ~sh_tx[{byte_idx, bcnt}];
			ACK1:  sda_oe_o = sh_addr[0] && !last_byte; // Master ACK on reads
			STOP: begin
				sda_oe_o = (q != 2'd3);   // SDA rises while SCL is high
				scl_oe_o = (q == 2'd0);
			end
			default: ;
		endcase
	end

endmodule

// File: hdl/i2c_scl_div.sv
`timescale 1ns/100ps

module i2c_scl_div #(
	parameter int CLK_DIV = 4 // clk_i cycles per quarter SCL period
) (
	input  logic clk_i,
	input  logic rst_i,
	input  logic run_i,
	output logic tick_o
);

	localparam int CW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CW-1:0] cnt_q;
	logic          wrap;

	assign wrap = (cnt_q == CW'(CLK_DIV - 1));

	// Held clear while idle so the first quarter is a full period
	always_ff @(posedge clk_i) begin
		if (rst_i || !run_i) begin
			cnt_q <= '0;
		end else if (wrap) begin
			cnt_q <= '0;
		end else begin
			cnt_q <= cnt_q + 1'b1;
		end
	end

	assign tick_o = run_i & wrap;

endmodule

// File: hdl/i2c_regs.sv
`timescale 1ns/100ps

module i2c_regs (
	input  logic              clk_i,
	input  logic              rst_i,
	input  logic              write_i,
	input  i2c_pkg::byte_en_t data_be_i,
	input  i2c_pkg::reg_addr_t addr_i,
	input  i2c_pkg::word_t    wdata_i,
	output i2c_pkg::word_t    rdata_o,
	i2c_ctrl_if.regs          ctrl
);
	import i2c_pkg::*;

	byte_cnt_t   nby_q;
	slave_addr_t adr_q;
	word_t       tdr_q;
	word_t       rdr_q;

	logic        req_q;
	logic        rnw_q;
	logic        wr_done_q;
	logic        rd_done_q;
	logic        nack_q;

	logic [3:0]  lane_we;
	reg_addr_t   lane_addr [4];
	logic        cfg_we;
	logic [7:0]  cfg_wbyte;
	logic [7:0]  cfg_rbyte;
	logic        xfer_end;

	assign lane_we  = data_be_i & {4{write_i}};
	assign xfer_end = req_q & ctrl.ack;

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			lane_addr[k] = addr_i + reg_addr_t'(k); // Lane k hits addr_i + k
		end
	end

	// CFG lives in a single byte, so at most one lane can hit it
	always_comb begin
		cfg_we    = 1'b0;
		cfg_wbyte = 8'h00;
		for (int k = 0; k < 4; k++) begin
			if (lane_we[k] && lane_addr[k] == REG_CFG) begin
				cfg_we    = 1'b1;
				cfg_wbyte = wdata_i[8*k +: 8];
			end
		end
	end

	always_comb begin
		cfg_rbyte              = 8'h00;
		cfg_rbyte[CFG_WR_GO]   = req_q & ~rnw_q;
		cfg_rbyte[CFG_WR_DONE] = wr_done_q;
		cfg_rbyte[CFG_RD_GO]   = req_q & rnw_q;
		cfg_rbyte[CFG_RD_DONE] = rd_done_q;
		cfg_rbyte[CFG_NACK]    = nack_q;
	end

	function automatic logic [7:0] reg_byte(input reg_addr_t a);
		logic [7:0] rb;
		rb = 8'h00;
		case ({a[4:2], 2'b00})
			REG_NBY: if (a[1:0] == 2'd0) rb = {5'b0, nby_q == 2'd0, nby_q}; // Bit 2 flags four bytes
			REG_ADR: if (a[1:0] == 2'd0) rb = {1'b0, adr_q};
			REG_RDR: rb = rdr_q[{a[1:0], 3'b000} +: 8];
			REG_TDR: rb = tdr_q[{a[1:0], 3'b000} +: 8];
			REG_CFG: if (a[1:0] == 2'd0) rb = cfg_rbyte;
			default: rb = 8'h00;
		endcase
		return rb;
	endfunction

	always_comb begin
		for (int k = 0; k < 4; k++) begin
			rdata_o[8*k +: 8] = data_be_i[k] ? reg_byte(lane_addr[k]) : 8'h00;
		end
	end

	// Configuration payload
	always_ff @(posedge clk_i) begin
		for (int k = 0; k < 4; k++) begin
			if (lane_we[k]) begin
				case ({lane_addr[k][4:2], 2'b00})
					REG_NBY: if (lane_addr[k][1:0] == 2'd0) nby_q <= wdata_i[8*k +: 2];
					REG_ADR: if (lane_addr[k][1:0] == 2'd0) adr_q <= wdata_i[8*k +: 7];
					REG_TDR: tdr_q[{lane_addr[k][1:0], 3'b000} +: 8] <= wdata_i[8*k +: 8];
					default: ;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (xfer_end && rnw_q) rdr_q <= ctrl.rdr;
	end

	// Requester side of the handshake with the engine
	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			req_q     <= 1'b0;
			rnw_q     <= 1'b0;
			wr_done_q <= 1'b0;
			rd_done_q <= 1'b0;
			nack_q    <= 1'b0;
		end else begin
			if (cfg_we) begin
				if (cfg_wbyte[CFG_WR_DONE]) wr_done_q <= 1'b0; // Write one to clear
				if (cfg_wbyte[CFG_RD_DONE]) rd_done_q <= 1'b0;
				if (cfg_wbyte[CFG_NACK])    nack_q    <= 1'b0;
				if (!req_q && (cfg_wbyte[CFG_WR_GO] || cfg_wbyte[CFG_RD_GO])) begin
					req_q <= 1'b1;
					rnw_q <= cfg_wbyte[CFG_RD_GO]; // Read wins
				end
			end
			if (xfer_end) begin
				req_q  <= 1'b0;
				nack_q <= ctrl.nack;
				if (rnw_q) rd_done_q <= 1'b1;
				else       wr_done_q <= 1'b1;
			end
		end
	end

	assign ctrl.req        = req_q;
	assign ctrl.rnw        = rnw_q;
	assign ctrl.slave_addr = adr_q;
	assign ctrl.nby        = nby_q;
	assign ctrl.tdr        = tdr_q;

endmodule

// File: hdl/i2c_ctrl_if.sv
`timescale 1ns/100ps

interface i2c_ctrl_if;
	import i2c_pkg::*;

	// Request side, held stable while req is high
	logic        req;
	logic        rnw;
	slave_addr_t slave_addr;
	byte_cnt_t   nby;
	word_t       tdr;

	// Result side, valid while ack is high
	logic        ack;
	logic        nack;
	word_t       rdr;

	modport regs (
		output req, rnw, slave_addr, nby, tdr,
		input  ack, nack, rdr
	);

	modport engine (
		input  req, rnw, slave_addr, nby, tdr,
		output ack, nack, rdr
	);

endinterface

// File: hdl/i2c_pkg.sv
package i2c_pkg;

	typedef logic [4:0]  reg_addr_t;   // Byte address on the CPU bus
	typedef logic [3:0]  byte_en_t;
	typedef logic [31:0] word_t;
	typedef logic [6:0]  slave_addr_t;
	typedef logic [1:0]  byte_cnt_t;   // Zero means four bytes

	// Register map
	localparam reg_addr_t REG_NBY = 5'h00;
	localparam reg_addr_t REG_ADR = 5'h04;
	localparam reg_addr_t REG_RDR = 5'h08;
	localparam reg_addr_t REG_TDR = 5'h0C;
	localparam reg_addr_t REG_CFG = 5'h10;

	// CFG bit positions
	localparam int unsigned CFG_WR_GO   = 0;
	localparam int unsigned CFG_WR_DONE = 1;
	localparam int unsigned CFG_RD_GO   = 2;
	localparam int unsigned CFG_RD_DONE = 3;
	localparam int unsigned CFG_NACK    = 4;

	typedef enum logic [2:0] {
		IDLE,
		START,
		ADDR,
		ACK0,
		WDATA,
		RDATA,
		ACK1,
		STOP
	} eng_state_e;

endpackage
